// File: include/barrierField_defs.svh
`ifndef BARRIERFIELD_DEFS_SVH
`define BARRIERFIELD_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Screen geometry
//////////////////////////////////////////////////////////////////////

// Width of one screen axis from the video scan
`define COORD_WIDTH 11

//////////////////////////////////////////////////////////////////////
// Barrier layout
//////////////////////////////////////////////////////////////////////

// Barriers across the field
`define BARRIER_COUNT 4

// Blocks along each side of one barrier
`define BLOCKS_PER_SIDE 4

// Block size is 16 pixels
`define BLOCK_SHIFT 4

// Barrier pitch is 128 pixels
// Barrier index then sits in the x offset bits above this shift
`define BARRIER_PITCH_SHIFT 7

// Left edge of barrier 0
`define FIELD_LEFT 64

// Top edge shared by all barriers
`define FIELD_TOP 400

//////////////////////////////////////////////////////////////////////
// Block health
//////////////////////////////////////////////////////////////////////

// Fresh block
// Zero means the block is gone
`define HEALTH_MAX 3

`endif

// File: source/barrierPkg.sv
`include "barrierField_defs.svh"

package barrierPkg;

    //////////////////////////////////////////////////////////////////////
    // Screen space
    //////////////////////////////////////////////////////////////////////

    // One axis of a screen position
    typedef logic [`COORD_WIDTH-1:0] screenCoord;

    // Full screen position
    // Pixel scan and player laser both use this
    typedef struct packed {
        screenCoord x;
        screenCoord y;
    } screenPoint;

    //////////////////////////////////////////////////////////////////////
    // Block addressing
    //////////////////////////////////////////////////////////////////////

    // Which barrier
    typedef logic [$clog2(`BARRIER_COUNT)-1:0] barrierIndex;

    // Column or row inside one barrier
    typedef logic [$clog2(`BLOCKS_PER_SIDE)-1:0] blockIndex;

    // Flat 6-bit address into the health array
    // Barrier in the top bits, row in the bottom bits
    typedef struct packed {
        barrierIndex barrier;
        blockIndex   column;
        blockIndex   row;
    } blockAddress;

    //////////////////////////////////////////////////////////////////////
    // Block state and display
    //////////////////////////////////////////////////////////////////////

    // Health of one block
    // Three bits so it drops straight into the green field
    typedef logic [2:0] blockHealth;

    // RGB332
    // Red in [7:5], green in [4:2], blue in [1:0]
    typedef logic [7:0] pixelColour;

    // Locator result
    // Address is zero whenever valid is low
    typedef struct packed {
        logic        valid;
        blockAddress address;
    } blockHit;

endpackage

// File: source/barrierLocator.sv
`timescale 1ns/1ps
`include "barrierField_defs.svh"

// Screen point to barrier block address
// Pure combinational decode
module barrierLocator (
    input  barrierPkg::screenPoint point,
    output barrierPkg::blockHit    hit
);

    //////////////////////////////////////////////////////////////////////
    // Derived geometry
    //////////////////////////////////////////////////////////////////////

    // Barrier width as seen inside one pitch slot
    localparam logic [`BARRIER_PITCH_SHIFT-1:0] pitchSpan =
        (`BARRIER_PITCH_SHIFT)'(`BLOCKS_PER_SIDE << `BLOCK_SHIFT);

    // Barrier height in screen units
    localparam barrierPkg::screenCoord barrierHeight =
        barrierPkg::screenCoord'(`BLOCKS_PER_SIDE << `BLOCK_SHIFT);

    // All pitch slots together
    localparam barrierPkg::screenCoord fieldSpan =
        barrierPkg::screenCoord'(`BARRIER_COUNT << `BARRIER_PITCH_SHIFT);

    // Field origin
    localparam barrierPkg::screenCoord fieldLeft =
        barrierPkg::screenCoord'(`FIELD_LEFT);
    localparam barrierPkg::screenCoord fieldTop =
        barrierPkg::screenCoord'(`FIELD_TOP);

    //////////////////////////////////////////////////////////////////////
    // Offsets from the field origin
    //////////////////////////////////////////////////////////////////////

    barrierPkg::screenCoord xOffset;
    barrierPkg::screenCoord yOffset;
    logic [`BARRIER_PITCH_SHIFT-1:0] xInPitch;
    logic xInside;
    logic yInside;
    logic inBarrier;
    barrierPkg::blockAddress address;

    // Points left of or above the origin wrap to large values
    // Range checks below then reject them
    assign xOffset = point.x - fieldLeft;
    assign yOffset = point.y - fieldTop;

    // Position inside the current pitch slot
    assign xInPitch = xOffset[`BARRIER_PITCH_SHIFT-1:0];

    // Inside the four slots and on the barrier part of the slot
    // Rest of the slot is the gap to the next barrier
    assign xInside = (xOffset < fieldSpan) && (xInPitch < pitchSpan);

    // Inside the barrier band
    assign yInside = yOffset < barrierHeight;

    assign inBarrier = xInside && yInside;

    //////////////////////////////////////////////////////////////////////
    // Address decode by bit fields
    //////////////////////////////////////////////////////////////////////

    // Barrier from the pitch bits
    assign address.barrier =
        xOffset[`BARRIER_PITCH_SHIFT +: $bits(barrierPkg::barrierIndex)];

    // Column and row from the block bits
    assign address.column = xOffset[`BLOCK_SHIFT +: $bits(barrierPkg::blockIndex)];
    assign address.row    = yOffset[`BLOCK_SHIFT +: $bits(barrierPkg::blockIndex)];

    // Address forced to zero off the field
    assign hit.valid   = inBarrier;
    assign hit.address = inBarrier ? address : '0;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Clean address whenever the point misses the field
    always_comb begin
        assert (hit.valid || hit.address == '0)
            else $error("barrierLocator address %0h with no hit", hit.address);
    end

endmodule

// File: source/barrierHealthStore.sv
`timescale 1ns/1ps
`include "barrierField_defs.svh"

// Health of every barrier block
// Laser damage and registered pixel shading
module barrierHealthStore (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   restart,
    input  barrierPkg::blockHit    pixelHit,
    input  barrierPkg::blockHit    laserHit,
    output logic                   isBarrier,
    output barrierPkg::pixelColour colour
);

    //////////////////////////////////////////////////////////////////////
    // Sizes and constants
    //////////////////////////////////////////////////////////////////////

    // One entry per block over all barriers
    // Matches the 6-bit address range exactly
    localparam int blockTotal = `BARRIER_COUNT * `BLOCKS_PER_SIDE * `BLOCKS_PER_SIDE;

    // Fresh block value
    localparam barrierPkg::blockHealth fullHealth =
        barrierPkg::blockHealth'(`HEALTH_MAX);

    // Last column and bottom row index
    localparam barrierPkg::blockIndex lastIndex =
        barrierPkg::blockIndex'(`BLOCKS_PER_SIDE - 1);

    //////////////////////////////////////////////////////////////////////
    // Start pattern
    //////////////////////////////////////////////////////////////////////

    // Notched shape
    // Outer columns lose the bottom row
    // Inner columns lose the bottom two rows
    function automatic barrierPkg::blockHealth notchHealth(
        barrierPkg::blockAddress address
    );
        logic edgeColumn;
        logic emptyBlock;
        edgeColumn = (address.column == '0) || (address.column == lastIndex);
        emptyBlock = (address.row == lastIndex) ||
                     (!edgeColumn && address.row == lastIndex - barrierPkg::blockIndex'(1));
        return emptyBlock ? '0 : fullHealth;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Health array
    //////////////////////////////////////////////////////////////////////

    barrierPkg::blockHealth health [blockTotal];

    // Current value under the laser
    barrierPkg::blockHealth laserHealth;
    logic laserLive;

    assign laserHealth = health[laserHit.address];

    // Only live blocks take damage
    // Empty blocks stay at zero
    assign laserLive = laserHit.valid && (laserHealth != '0);

    // Restore wins over damage on the same edge
    // Held laser keeps hitting every cycle
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            for (int i = 0; i < blockTotal; i++) begin
                health[i] <= notchHealth(barrierPkg::blockAddress'(i));
            end
        end else if (laserLive) begin
            health[laserHit.address] <= laserHealth - barrierPkg::blockHealth'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pixel shading
    //////////////////////////////////////////////////////////////////////

    barrierPkg::blockHealth pixelHealth;
    logic pixelLive;

    // Read before this edge's damage lands
    assign pixelHealth = health[pixelHit.address];
    assign pixelLive   = pixelHit.valid && (pixelHealth != '0);

    // One cycle from scan point to output
    // Health in green with red and blue dark
    always_ff @(posedge clk) begin
        if (reset) begin
            isBarrier <= 1'b0;
            colour    <= '0;
        end else begin
            isBarrier <= pixelLive;
            colour    <= pixelLive ? {3'b000, pixelHealth, 2'b00} : '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Dark output whenever no block is shown
    assert property (@(posedge clk) !isBarrier |-> colour == '0)
        else $error("barrierHealthStore colour %0h with isBarrier low", colour);

    // Per-entry checks
    for (genvar g = 0; g < blockTotal; g++) begin : entryChecks

        // Decrement never wraps past zero
        assert property (@(posedge clk) disable iff (reset)
            health[g] <= fullHealth)
            else $error("barrierHealthStore entry %0d above max", g);

        // Dead block comes back only through restore
        assert property (@(posedge clk)
            (health[g] == '0 && !reset && !restart) |=> health[g] == '0)
            else $error("barrierHealthStore entry %0d revived", g);

    end

endmodule

// File: source/barrierField.sv
`timescale 1ns/1ps

// Barrier field of the video pipeline
// Two locators feed one health store
module barrierField (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   restart,
    input  barrierPkg::screenPoint pixel,
    input  barrierPkg::screenPoint laser,
    output logic                   isBarrier,
    output barrierPkg::pixelColour colour
);

    //////////////////////////////////////////////////////////////////////
    // Block decode
    //////////////////////////////////////////////////////////////////////

    // Pixel scan decode
    // Drives the display read
    barrierPkg::blockHit pixelHit;

    // Player laser decode
    // Drives the damage write
    barrierPkg::blockHit laserHit;

    // Current scan point
    barrierLocator pixelLocator (
        .point (pixel),
        .hit   (pixelHit)
    );

    // Player laser position
    // Off-field coordinates come back invalid
    barrierLocator laserLocator (
        .point (laser),
        .hit   (laserHit)
    );

    //////////////////////////////////////////////////////////////////////
    // Health and shading
    //////////////////////////////////////////////////////////////////////

    // Registered outputs
    // One cycle after the pixel
    barrierHealthStore store (
        .clk       (clk),
        .reset     (reset),
        .restart   (restart),
        .pixelHit  (pixelHit),
        .laserHit  (laserHit),
        .isBarrier (isBarrier),
        .colour    (colour)
    );

endmodule

// File: bench/barrierFieldModel.sv
`timescale 1ns/1ps
`include "barrierField_defs.svh"

// Reference model of the barrier field
// Predicts the DUT outputs one cycle ahead and checks them on every edge
module barrierFieldModel (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   restart,
    input  barrierPkg::screenPoint pixel,
    input  barrierPkg::screenPoint laser,
    input  logic                   isBarrier,
    input  barrierPkg::pixelColour colour,
    output logic                   checkFailed
);

    //////////////////////////////////////////////////////////////////////
    // Geometry from the shared macros
    //////////////////////////////////////////////////////////////////////

    localparam int blockSize   = 1 << `BLOCK_SHIFT;
    localparam int pitch       = 1 << `BARRIER_PITCH_SHIFT;
    localparam int barrierSide = `BLOCKS_PER_SIDE * blockSize;
    localparam int blockTotal  = `BARRIER_COUNT * `BLOCKS_PER_SIDE * `BLOCKS_PER_SIDE;

    // Flat block number, barrier then column then row
    // Minus one when the point misses every barrier
    function automatic int blockNumber(barrierPkg::screenPoint p);
        int dx;
        int dy;
        int slot;
        int inSlot;
        dx = int'(p.x) - `FIELD_LEFT;
        dy = int'(p.y) - `FIELD_TOP;
        if (dx < 0 || dy < 0 || dy >= barrierSide) return -1;
        slot   = dx / pitch;
        inSlot = dx % pitch;
        // Past the last barrier or in a gap
        if (slot >= `BARRIER_COUNT || inSlot >= barrierSide) return -1;
        return (slot * `BLOCKS_PER_SIDE + inSlot / blockSize) * `BLOCKS_PER_SIDE
            + dy / blockSize;
    endfunction

    // Notched start shape
    function automatic int startHealth(int n);
        int column;
        int row;
        column = (n / `BLOCKS_PER_SIDE) % `BLOCKS_PER_SIDE;
        row    = n % `BLOCKS_PER_SIDE;
        if (row == `BLOCKS_PER_SIDE - 1) return 0;
        // Inner columns also lose the row above
        if (column != 0 && column != `BLOCKS_PER_SIDE - 1 && row == `BLOCKS_PER_SIDE - 2)
            return 0;
        return `HEALTH_MAX;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Expected state
    //////////////////////////////////////////////////////////////////////

    int health [blockTotal];
    int pixelBlock;
    int laserBlock;
    logic predLive;
    barrierPkg::pixelColour predColour;
    logic expIsBarrier;
    barrierPkg::pixelColour expColour;
    logic failFlag = 1'b0;

    assign checkFailed = failFlag;

    always_comb begin
        pixelBlock = blockNumber(pixel);
        laserBlock = blockNumber(laser);
    end

    // Display prediction from health before this edge
    always_comb begin
        predLive   = 1'b0;
        predColour = '0;
        if (pixelBlock >= 0) begin
            if (health[pixelBlock] > 0) begin
                predLive   = 1'b1;
                // Green sits in bits 4 to 2
                predColour = barrierPkg::pixelColour'(health[pixelBlock] << 2);
            end
        end
    end

    // Restore first, otherwise one step of damage
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            for (int i = 0; i < blockTotal; i++) begin
                health[i] <= startHealth(i);
            end
        end else if (laserBlock >= 0) begin
            if (health[laserBlock] > 0) health[laserBlock] <= health[laserBlock] - 1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            expIsBarrier <= 1'b0;
            expColour    <= '0;
        end else begin
            expIsBarrier <= predLive;
            expColour    <= predColour;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output checks
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (reset) isBarrier == expIsBarrier)
        else begin
            $display("** Error at %0t: isBarrier = %0b, expected %0b",
                $time, $sampled(isBarrier), $sampled(expIsBarrier));
            failFlag = 1'b1;
        end

    assert property (@(posedge clk) disable iff (reset) colour == expColour)
        else begin
            $display("** Error at %0t: colour = %02h, expected %02h",
                $time, $sampled(colour), $sampled(expColour));
            failFlag = 1'b1;
        end

endmodule

// File: bench/barrierFieldTb.sv
`timescale 1ns/1ps
`include "barrierField_defs.svh"

module barrierFieldTb;

    localparam int clockPeriod    = 10;
    localparam int resetCycles    = 5;
    // Upper bound on the directed steps
    localparam int directedCycles = 150;
    localparam int randomCycles   = 2000;
    localparam int stimulusCycles = resetCycles + directedCycles + randomCycles;

    localparam int blockSize   = 1 << `BLOCK_SHIFT;
    localparam int pitch       = 1 << `BARRIER_PITCH_SHIFT;
    localparam int barrierSide = `BLOCKS_PER_SIDE * blockSize;

    logic clk;
    logic reset;
    logic restart;
    barrierPkg::screenPoint pixel;
    barrierPkg::screenPoint laser;
    logic isBarrier;
    barrierPkg::pixelColour colour;
    logic checkFailed;
    logic [31:0] rngState;

    barrierField DUT (
        .clk       (clk),
        .reset     (reset),
        .restart   (restart),
        .pixel     (pixel),
        .laser     (laser),
        .isBarrier (isBarrier),
        .colour    (colour)
    );

    barrierFieldModel model (
        .clk         (clk),
        .reset       (reset),
        .restart     (restart),
        .pixel       (pixel),
        .laser       (laser),
        .isBarrier   (isBarrier),
        .colour      (colour),
        .checkFailed (checkFailed)
    );

    always #(clockPeriod / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic failRun(string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic barrierPkg::screenPoint makePoint(int x, int y);
        barrierPkg::screenPoint p;
        p.x = barrierPkg::screenCoord'(x);
        p.y = barrierPkg::screenCoord'(y);
        return p;
    endfunction

    // Middle pixel of one block
    function automatic barrierPkg::screenPoint blockCentre(int barrier, int column, int row);
        return makePoint(`FIELD_LEFT + barrier * pitch + column * blockSize + blockSize / 2,
            `FIELD_TOP + row * blockSize + blockSize / 2);
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] state);
        logic [31:0] v;
        v = state ^ (state << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic drawRandom(output logic [31:0] value);
        rngState = xorshift(rngState);
        value = rngState;
    endtask

    // Seven in eight land on or just around the field
    task automatic randomPoint(output barrierPkg::screenPoint p);
        logic [31:0] r;
        drawRandom(r);
        if (r[2:0] != 3'd0) begin
            p = makePoint(`FIELD_LEFT - blockSize
                    + int'(r[31:16]) % (`BARRIER_COUNT * pitch + 2 * blockSize),
                `FIELD_TOP - blockSize + int'(r[15:8]) % (barrierSide + 2 * blockSize));
        end else begin
            p = makePoint(int'(r[31:21]), int'(r[20:10]));
        end
    endtask

    // One cycle of stimulus driven on the edge
    task automatic driveStep(barrierPkg::screenPoint p, barrierPkg::screenPoint l, logic r);
        @(posedge clk);
        pixel   <= p;
        laser   <= l;
        restart <= r;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        barrierPkg::screenPoint offField;
        barrierPkg::screenPoint target;
        barrierPkg::screenPoint randPixel;
        barrierPkg::screenPoint randLaser;
        logic [31:0] roll;
        offField = makePoint(0, 0);
        clk      = 1'b0;
        reset    = 1'b1;
        restart  = 1'b0;
        // Scan parked on a live block while reset holds the outputs low
        pixel    = blockCentre(0, 0, 0);
        laser    = offField;
        rngState = 32'h9f52;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;

        // One pixel in each block of the start pattern
        for (int b = 0; b < `BARRIER_COUNT; b++)
            for (int c = 0; c < `BLOCKS_PER_SIDE; c++)
                for (int r = 0; r < `BLOCKS_PER_SIDE; r++)
                    driveStep(blockCentre(b, c, r), offField, 1'b0);

        // Gaps between barriers and the area around the field
        for (int b = 0; b < `BARRIER_COUNT; b++) begin
            driveStep(makePoint(`FIELD_LEFT + b * pitch + barrierSide, `FIELD_TOP),
                offField, 1'b0);
            driveStep(makePoint(`FIELD_LEFT + b * pitch + pitch - 1, `FIELD_TOP + 20),
                offField, 1'b0);
        end
        driveStep(makePoint(`FIELD_LEFT - 1, `FIELD_TOP + 8), offField, 1'b0);
        driveStep(makePoint(`FIELD_LEFT + 8, `FIELD_TOP - 1), offField, 1'b0);
        driveStep(makePoint(`FIELD_LEFT + 8, `FIELD_TOP + barrierSide), offField, 1'b0);

        // Held laser walks one block down to empty
        target = blockCentre(1, 0, 0);
        repeat (5) driveStep(target, target, 1'b0);
        repeat (3) driveStep(target, offField, 1'b0);

        // Notch block and stray lasers change nothing
        target = blockCentre(2, 1, 3);
        repeat (2) driveStep(target, target, 1'b0);
        target = blockCentre(2, 0, 0);
        repeat (2) driveStep(target, offField, 1'b0);
        driveStep(target, makePoint(`FIELD_LEFT + 2 * pitch + barrierSide + 4, `FIELD_TOP),
            1'b0);
        driveStep(target, offField, 1'b0);

        // Restart beats a hit on the same edge
        target = blockCentre(3, 2, 1);
        repeat (2) driveStep(target, target, 1'b0);
        driveStep(target, target, 1'b1);
        repeat (2) driveStep(target, offField, 1'b0);
        // Block emptied earlier comes back
        target = blockCentre(1, 0, 0);
        driveStep(target, offField, 1'b1);
        repeat (2) driveStep(target, offField, 1'b0);

        // Random traffic with a restart about one cycle in 64
        for (int i = 0; i < randomCycles; i++) begin
            randomPoint(randPixel);
            randomPoint(randLaser);
            drawRandom(roll);
            driveStep(randPixel, randLaser, roll[5:0] == 6'd0);
        end

        driveStep(offField, offField, 1'b0);
        repeat (2) @(posedge clk);
        if (checkFailed) begin
            failRun("Model check failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Failure and watchdog
    //////////////////////////////////////////////////////////////////////

    always @(posedge checkFailed) begin
        failRun("DUT output differs from the model");
    end

    initial begin
        #(2 * stimulusCycles * clockPeriod);
        failRun("Watchdog expired before the stimulus finished");
    end

endmodule

// File: files.f
+incdir+include
source/barrierPkg.sv
source/barrierLocator.sv
source/barrierHealthStore.sv
source/barrierField.sv
bench/barrierFieldModel.sv
bench/barrierFieldTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module barrierFieldTb -o barrierFieldSim
	./obj_dir/barrierFieldSim

clean:
	rm -rf obj_dir
